/* mem_xbar_params.svh */
/*
 * Sizes of the rasterizer memory port. MEM_XBAR_ID_W must stay the sum of the
 * source index and local ID widths, and MEM_XBAR_NUM_SRC must fit in the index.
 */
`ifndef MEM_XBAR_PARAMS_SVH
`define MEM_XBAR_PARAMS_SVH

// Number of read requesters merged onto the memory port
`define MEM_XBAR_NUM_SRC 3

// Source index carried in the upper memory ID bits
`define MEM_XBAR_SRC_IDX_W 2

// ID width as seen by one requester
`define MEM_XBAR_LOCAL_ID_W 2

// Memory side ID holds the source index above the local ID
`define MEM_XBAR_ID_W (`MEM_XBAR_SRC_IDX_W + `MEM_XBAR_LOCAL_ID_W)

`define MEM_XBAR_ADDR_W 32
`define MEM_XBAR_DATA_W 32

// A burst carries len + 1 beats
`define MEM_XBAR_LEN_W 8
`define MEM_XBAR_RESP_W 2

// Read beats held while the sources stall
`define MEM_XBAR_RD_FIFO_DEPTH 4

`endif

/* mem_xbar_pkg.sv */
/*
 * Types shared by the memory port blocks, sized from mem_xbar_params.svh.
 * mem_id_t is {source index, local ID}, source index in the upper bits.
 */
`default_nettype none

`include "mem_xbar_params.svh"

package mem_xbar_pkg;

    // Which requester a transaction belongs to
    typedef logic [`MEM_XBAR_SRC_IDX_W-1:0] src_idx_t;

    // Transaction ID private to one requester
    typedef logic [`MEM_XBAR_LOCAL_ID_W-1:0] local_id_t;

    // ID on the external memory port
    typedef logic [`MEM_XBAR_ID_W-1:0] mem_id_t;

    typedef logic [`MEM_XBAR_ADDR_W-1:0] addr_t;
    typedef logic [`MEM_XBAR_DATA_W-1:0] data_t;

    // Burst length, number of beats minus one
    typedef logic [`MEM_XBAR_LEN_W-1:0] len_t;

    typedef logic [`MEM_XBAR_RESP_W-1:0] resp_t;

endpackage

`default_nettype wire

/* rd_beat_if.sv */
/*
 * One buffered read beat on its way back to a requester, valid/ready handshake.
 * The ID still holds the source index in its upper bits.
 */
`timescale 1ns/1ps
`default_nettype none

interface rd_beat_if import mem_xbar_pkg::*; (
    input wire aclk,
    input wire rst_n
);

    logic    valid;
    logic    ready;
    mem_id_t id;
    data_t   data;
    resp_t   resp;
    logic    last;

    // Buffer side
    modport src (
        input  aclk,
        input  rst_n,
        output valid,
        output id,
        output data,
        output resp,
        output last,
        input  ready
    );

    // Router side, which also clocks its checks from here
    modport dst (
        input  aclk,
        input  rst_n,
        input  valid,
        input  id,
        input  data,
        input  resp,
        input  last,
        output ready
    );

endinterface

`default_nettype wire

/* ar_arbiter.sv */
/*
 * Round-robin merge of the source AR channels into one registered AR channel.
 * Accepts one request per cycle, and none while the output register is stalled.
 */
`timescale 1ns/1ps
`default_nettype none

`include "mem_xbar_params.svh"

module ar_arbiter import mem_xbar_pkg::*; (
    input  wire                                  aclk,
    input  wire                                  rst_n,

    input  wire  [`MEM_XBAR_NUM_SRC-1:0]         s_ar_valid,
    output logic [`MEM_XBAR_NUM_SRC-1:0]         s_ar_ready,
    input  wire  local_id_t [`MEM_XBAR_NUM_SRC-1:0] s_ar_id,
    input  wire  addr_t [`MEM_XBAR_NUM_SRC-1:0]  s_ar_addr,
    input  wire  len_t [`MEM_XBAR_NUM_SRC-1:0]   s_ar_len,

    output logic                                 m_ar_valid,
    input  wire                                  m_ar_ready,
    output mem_id_t                              m_ar_id,
    output addr_t                                m_ar_addr,
    output len_t                                 m_ar_len
);

    // Source that gets the first look in the next arbitration
    src_idx_t rr_ptr;

    logic     load;
    logic     grant_valid;
    src_idx_t grant_idx;

    // The register can take a new request when empty or emptying this cycle
    assign load = !m_ar_valid || m_ar_ready;

    // First requester at or after the pointer wins
    always_comb begin
        int idx;
        grant_valid = 1'b0;
        grant_idx = '0;
        for (int k = 0; k < `MEM_XBAR_NUM_SRC; k++) begin
            idx = (int'(rr_ptr) + k) % `MEM_XBAR_NUM_SRC;
            if (!grant_valid && s_ar_valid[idx]) begin
                grant_valid = 1'b1;
                grant_idx = src_idx_t'(idx);
            end
        end
    end

    always_comb begin
        s_ar_ready = '0;
        if (load && grant_valid) begin
            s_ar_ready[grant_idx] = 1'b1;
        end
    end

    always_ff @(posedge aclk or negedge rst_n) begin
        if (!rst_n) begin
            m_ar_valid <= 1'b0;
            rr_ptr <= '0;
        end else if (load) begin
            m_ar_valid <= grant_valid;
            // The winner drops to last priority for the next round
            if (grant_valid) begin
                if (grant_idx == src_idx_t'(`MEM_XBAR_NUM_SRC - 1)) begin
                    rr_ptr <= '0;
                end else begin
                    rr_ptr <= grant_idx + 1'b1;
                end
            end
        end
    end

    // Tag the outgoing ID with the winner's index so the read data finds its way back
    always_ff @(posedge aclk) begin
        if (load && grant_valid) begin
            m_ar_id <= {grant_idx, s_ar_id[grant_idx]};
            m_ar_addr <= s_ar_addr[grant_idx];
            m_ar_len <= s_ar_len[grant_idx];
        end
    end

    // A pending request must not change before memory takes it
    ar_hold_stable: assert property (
        @(posedge aclk) disable iff (!rst_n)
        m_ar_valid && !m_ar_ready |=> m_ar_valid && $stable(m_ar_id)
            && $stable(m_ar_addr) && $stable(m_ar_len)
    );

    // A winner does not win twice in a row while every source is waiting
    ar_rr_rotate: assert property (
        @(posedge aclk) disable iff (!rst_n)
        ((|s_ar_ready) && (s_ar_valid == '1)) |=>
            !(load && (s_ar_valid == '1)) || (s_ar_ready != $past(s_ar_ready))
    );

endmodule

`default_nettype wire

/* rd_beat_fifo.sv */
/*
 * Circular buffer for memory read beats, MEM_XBAR_RD_FIFO_DEPTH entries deep.
 * rready drops only when full. A new beat shows at the output one cycle later.
 */
`timescale 1ns/1ps
`default_nettype none

`include "mem_xbar_params.svh"

module rd_beat_fifo import mem_xbar_pkg::*; (
    input  wire          aclk,
    input  wire          rst_n,

    input  wire          m_r_valid,
    output logic         m_r_ready,
    input  wire mem_id_t m_r_id,
    input  wire data_t   m_r_data,
    input  wire resp_t   m_r_resp,
    input  wire          m_r_last,

    rd_beat_if.src       beat
);

    localparam int depth = `MEM_XBAR_RD_FIFO_DEPTH;
    localparam int ptr_w = (depth > 1) ? $clog2(depth) : 1;
    localparam int cnt_w = $clog2(depth + 1);

    mem_id_t            id_mem   [depth];
    data_t              data_mem [depth];
    resp_t              resp_mem [depth];
    logic               last_mem [depth];

    logic [ptr_w-1:0]   wr_ptr;
    logic [ptr_w-1:0]   rd_ptr;
    logic [cnt_w-1:0]   count;
    logic               push;
    logic               pop;

    // Depth need not be a power of two
    function automatic logic [ptr_w-1:0] next_ptr(input logic [ptr_w-1:0] p);
        return (p == ptr_w'(depth - 1)) ? '0 : p + 1'b1;
    endfunction

    assign m_r_ready = (count != cnt_w'(depth));
    assign push = m_r_valid && m_r_ready;
    assign pop = beat.valid && beat.ready;

    // The head entry is presented straight from the storage registers
    assign beat.valid = (count != '0);
    assign beat.id = id_mem[rd_ptr];
    assign beat.data = data_mem[rd_ptr];
    assign beat.resp = resp_mem[rd_ptr];
    assign beat.last = last_mem[rd_ptr];

    always_ff @(posedge aclk) begin
        if (push) begin
            id_mem[wr_ptr] <= m_r_id;
            data_mem[wr_ptr] <= m_r_data;
            resp_mem[wr_ptr] <= m_r_resp;
            last_mem[wr_ptr] <= m_r_last;
        end
    end

    always_ff @(posedge aclk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count <= '0;
        end else begin
            if (push) begin
                wr_ptr <= next_ptr(wr_ptr);
            end
            if (pop) begin
                rd_ptr <= next_ptr(rd_ptr);
            end
            // Simultaneous push and pop leave the occupancy unchanged
            if (push && !pop) begin
                count <= count + 1'b1;
            end else if (pop && !push) begin
                count <= count - 1'b1;
            end
        end
    end

    // Empty and full both leave the two pointers on the same entry
    fifo_ptr_match: assert property (
        @(posedge aclk) disable iff (!rst_n)
        (count == '0 || count == cnt_w'(depth)) |-> (wr_ptr == rd_ptr)
    );

    fifo_count_bound: assert property (
        @(posedge aclk) disable iff (!rst_n)
        count <= cnt_w'(depth)
    );

endmodule

`default_nettype wire

/* rd_resp_router.sv */
/*
 * Sends each buffered read beat to the source named in its upper ID bits.
 * Purely combinational. Data fields go to every source and only valid is steered
 */
`timescale 1ns/1ps
`default_nettype none

`include "mem_xbar_params.svh"

module rd_resp_router import mem_xbar_pkg::*; (
    rd_beat_if.dst                          beat,

    input  wire  [`MEM_XBAR_NUM_SRC-1:0]    s_r_ready,
    output logic [`MEM_XBAR_NUM_SRC-1:0]    s_r_valid,
    output local_id_t [`MEM_XBAR_NUM_SRC-1:0] s_r_id,
    output data_t [`MEM_XBAR_NUM_SRC-1:0]   s_r_data,
    output resp_t [`MEM_XBAR_NUM_SRC-1:0]   s_r_resp,
    output logic [`MEM_XBAR_NUM_SRC-1:0]    s_r_last
);

    src_idx_t  sel;
    local_id_t local_id;

    // Upper bits were added by the arbiter and are stripped again here
    assign sel = beat.id[`MEM_XBAR_ID_W-1:`MEM_XBAR_LOCAL_ID_W];
    assign local_id = beat.id[`MEM_XBAR_LOCAL_ID_W-1:0];

    always_comb begin
        for (int i = 0; i < `MEM_XBAR_NUM_SRC; i++) begin
            s_r_valid[i] = beat.valid && (sel == src_idx_t'(i));
            s_r_id[i] = local_id;
            s_r_data[i] = beat.data;
            s_r_resp[i] = beat.resp;
            s_r_last[i] = beat.last;
        end
    end

    // Only the addressed source can pop the buffer
    always_comb begin
        beat.ready = 1'b0;
        for (int i = 0; i < `MEM_XBAR_NUM_SRC; i++) begin
            if (sel == src_idx_t'(i)) begin
                beat.ready = s_r_ready[i];
            end
        end
    end

    // Memory must echo an ID that the arbiter could have issued
    route_src_in_range: assert property (
        @(posedge beat.aclk) disable iff (!beat.rst_n)
        beat.valid |-> (int'(sel) < `MEM_XBAR_NUM_SRC)
    );

endmodule

`default_nettype wire

/* rrx_mem_xbar.sv */
/*
 * Read-only memory port for the rasterizer with three requesters on one AXI-style AR/R.
 * No write channels. Memory must echo m_axi_arid on every read beat
 */
`timescale 1ns/1ps
`default_nettype none

module rrx_mem_xbar import mem_xbar_pkg::*; (
    input  wire            aclk,
    input  wire            rst_n,

    // Source 0 is the command path and sources 1 and 2 are the texture units
    input  wire            s0_ar_valid,
    output wire            s0_ar_ready,
    input  wire local_id_t s0_ar_id,
    input  wire addr_t     s0_ar_addr,
    input  wire len_t      s0_ar_len,
    input  wire            s1_ar_valid,
    output wire            s1_ar_ready,
    input  wire local_id_t s1_ar_id,
    input  wire addr_t     s1_ar_addr,
    input  wire len_t      s1_ar_len,
    input  wire            s2_ar_valid,
    output wire            s2_ar_ready,
    input  wire local_id_t s2_ar_id,
    input  wire addr_t     s2_ar_addr,
    input  wire len_t      s2_ar_len,

    output wire            s0_r_valid,
    input  wire            s0_r_ready,
    output wire local_id_t s0_r_id,
    output wire data_t     s0_r_data,
    output wire resp_t     s0_r_resp,
    output wire            s0_r_last,
    output wire            s1_r_valid,
    input  wire            s1_r_ready,
    output wire local_id_t s1_r_id,
    output wire data_t     s1_r_data,
    output wire resp_t     s1_r_resp,
    output wire            s1_r_last,
    output wire            s2_r_valid,
    input  wire            s2_r_ready,
    output wire local_id_t s2_r_id,
    output wire data_t     s2_r_data,
    output wire resp_t     s2_r_resp,
    output wire            s2_r_last,

    // External memory
    output wire            m_axi_arvalid,
    input  wire            m_axi_arready,
    output wire mem_id_t   m_axi_arid,
    output wire addr_t     m_axi_araddr,
    output wire len_t      m_axi_arlen,
    input  wire            m_axi_rvalid,
    output wire            m_axi_rready,
    input  wire mem_id_t   m_axi_rid,
    input  wire data_t     m_axi_rdata,
    input  wire resp_t     m_axi_rresp,
    input  wire            m_axi_rlast
);

    rd_beat_if beat_if (.aclk(aclk), .rst_n(rst_n));

    ar_arbiter u_ar_arbiter (
        .aclk       (aclk),
        .rst_n      (rst_n),
        .s_ar_valid ({s2_ar_valid, s1_ar_valid, s0_ar_valid}),
        .s_ar_ready ({s2_ar_ready, s1_ar_ready, s0_ar_ready}),
        .s_ar_id    ({s2_ar_id, s1_ar_id, s0_ar_id}),
        .s_ar_addr  ({s2_ar_addr, s1_ar_addr, s0_ar_addr}),
        .s_ar_len   ({s2_ar_len, s1_ar_len, s0_ar_len}),
        .m_ar_valid (m_axi_arvalid),
        .m_ar_ready (m_axi_arready),
        .m_ar_id    (m_axi_arid),
        .m_ar_addr  (m_axi_araddr),
        .m_ar_len   (m_axi_arlen)
    );

    rd_beat_fifo u_rd_beat_fifo (
        .aclk      (aclk),
        .rst_n     (rst_n),
        .m_r_valid (m_axi_rvalid),
        .m_r_ready (m_axi_rready),
        .m_r_id    (m_axi_rid),
        .m_r_data  (m_axi_rdata),
        .m_r_resp  (m_axi_rresp),
        .m_r_last  (m_axi_rlast),
        .beat      (beat_if.src)
    );

    rd_resp_router u_rd_resp_router (
        .beat      (beat_if.dst),
        .s_r_ready ({s2_r_ready, s1_r_ready, s0_r_ready}),
        .s_r_valid ({s2_r_valid, s1_r_valid, s0_r_valid}),
        .s_r_id    ({s2_r_id, s1_r_id, s0_r_id}),
        .s_r_data  ({s2_r_data, s1_r_data, s0_r_data}),
        .s_r_resp  ({s2_r_resp, s1_r_resp, s0_r_resp}),
        .s_r_last  ({s2_r_last, s1_r_last, s0_r_last})
    );

endmodule

`default_nettype wire

/* tb_rrx_mem_xbar.sv */
/*
 * Testbench for rrx_mem_xbar. Run from the project root so that mem_xbar_testdata.txt is found.
 * The memory model answers requests in order, and beat k of a burst carries address + 4k
 */
`timescale 1ns/1ps
`default_nettype none

`include "mem_xbar_params.svh"

module tb_rrx_mem_xbar import mem_xbar_pkg::*; ();

    localparam int num_src = `MEM_XBAR_NUM_SRC;
    localparam int num_req = 21;
    localparam int hs_timeout = 2000;
    localparam int done_timeout = 20000;

    logic               aclk;
    logic               rst_n;
    logic [num_src-1:0] ar_valid;
    wire  [num_src-1:0] ar_ready;
    local_id_t          ar_id [num_src];
    addr_t              ar_addr [num_src];
    len_t               ar_len [num_src];
    wire  [num_src-1:0] r_valid;
    logic [num_src-1:0] r_ready;
    wire  local_id_t    r_id [num_src];
    wire  data_t        r_data [num_src];
    wire  resp_t        r_resp [num_src];
    wire  [num_src-1:0] r_last;
    wire                m_axi_arvalid;
    logic               m_axi_arready;
    wire  mem_id_t      m_axi_arid;
    wire  addr_t        m_axi_araddr;
    wire  len_t         m_axi_arlen;
    logic               m_axi_rvalid;
    wire                m_axi_rready;
    mem_id_t            m_axi_rid;
    data_t              m_axi_rdata;
    resp_t              m_axi_rresp;
    logic               m_axi_rlast;

    // Entry layout is source [47:44], local ID [43:40], address [39:8], length [7:0]
    logic [47:0] req_mem [num_req];
    // Per source {local ID, address, length} in file order
    logic [41:0] exp_ar [num_src][$];
    // Granted but not yet seen on m_axi_ar, {memory ID, address, length}
    logic [43:0] granted_q [$];
    // Per source {local ID, data, last} for every expected beat
    logic [34:0] exp_beat [num_src][$];
    // Requests held by the memory model
    logic [43:0] mem_q [$];
    int errors;
    int checks;
    int rr_ptr_model;
    int rr_full_cnt;
    int beats_seen;
    int beats_total;

    rrx_mem_xbar DUT (
        .aclk(aclk),
        .rst_n(rst_n),
        .s0_ar_valid(ar_valid[0]), .s1_ar_valid(ar_valid[1]), .s2_ar_valid(ar_valid[2]),
        .s0_ar_ready(ar_ready[0]), .s1_ar_ready(ar_ready[1]), .s2_ar_ready(ar_ready[2]),
        .s0_ar_id(ar_id[0]), .s1_ar_id(ar_id[1]), .s2_ar_id(ar_id[2]),
        .s0_ar_addr(ar_addr[0]), .s1_ar_addr(ar_addr[1]), .s2_ar_addr(ar_addr[2]),
        .s0_ar_len(ar_len[0]), .s1_ar_len(ar_len[1]), .s2_ar_len(ar_len[2]),
        .s0_r_valid(r_valid[0]), .s1_r_valid(r_valid[1]), .s2_r_valid(r_valid[2]),
        .s0_r_ready(r_ready[0]), .s1_r_ready(r_ready[1]), .s2_r_ready(r_ready[2]),
        .s0_r_id(r_id[0]), .s1_r_id(r_id[1]), .s2_r_id(r_id[2]),
        .s0_r_data(r_data[0]), .s1_r_data(r_data[1]), .s2_r_data(r_data[2]),
        .s0_r_resp(r_resp[0]), .s1_r_resp(r_resp[1]), .s2_r_resp(r_resp[2]),
        .s0_r_last(r_last[0]), .s1_r_last(r_last[1]), .s2_r_last(r_last[2]),
        .m_axi_arvalid(m_axi_arvalid), .m_axi_arready(m_axi_arready),
        .m_axi_arid(m_axi_arid), .m_axi_araddr(m_axi_araddr), .m_axi_arlen(m_axi_arlen),
        .m_axi_rvalid(m_axi_rvalid), .m_axi_rready(m_axi_rready), .m_axi_rid(m_axi_rid),
        .m_axi_rdata(m_axi_rdata), .m_axi_rresp(m_axi_rresp), .m_axi_rlast(m_axi_rlast)
    );

    initial begin
        aclk = 1'b0;
        forever begin
            #2 aclk = ~aclk;
        end
    end

    task automatic note_failure(input string what);
        $display("%s", what);
        errors++;
    endtask

    task automatic check_eq(input string name, input logic [63:0] got, input logic [63:0] exp);
        checks++;
        assert (got == exp) else begin
            $display("error %s got %h expected %h", name, got, exp);
            errors++;
        end
    endtask

    task automatic load_requests();
        int s;
        int len;
        // Unloaded entries carry an invalid source and their own index
        for (int n = 0; n < num_req; n++) begin
            req_mem[n] = {4'hf, 44'(n)};
        end
        $readmemh("mem_xbar_testdata.txt", req_mem);
        beats_total = 0;
        for (int n = 0; n < num_req; n++) begin
            s = int'(req_mem[n][47:44]);
            len = int'(req_mem[n][7:0]);
            assert (s < num_src) else note_failure($sformatf("test data entry %0d is bad", n));
            if (s < num_src) begin
                exp_ar[s].push_back(req_mem[n][41:0]);
                for (int k = 0; k <= len; k++) begin
                    exp_beat[s].push_back({req_mem[n][41:40], req_mem[n][39:8] + 32'(4 * k),
                                           k == len});
                end
                beats_total += len + 1;
            end
        end
    endtask

    // One source walks through its own entries of the file in order
    task automatic issue_requests(input int s);
        int wait_cnt;
        for (int n = 0; n < num_req; n++) begin
            if (int'(req_mem[n][47:44]) == s) begin
                ar_id[s] = req_mem[n][41:40];
                ar_addr[s] = req_mem[n][39:8];
                ar_len[s] = req_mem[n][7:0];
                ar_valid[s] = 1'b1;
                wait_cnt = 0;
                do begin
                    @(negedge aclk);
                    wait_cnt++;
                end while (!ar_ready[s] && wait_cnt < hs_timeout);
                assert (ar_ready[s]) else
                    note_failure($sformatf("source %0d request was never accepted", s));
                @(posedge aclk);
                #1;
                ar_valid[s] = 1'b0;
            end
        end
    endtask

    // Memory responder, which also drives the random source rready gaps
    task automatic run_memory();
        int beat_k;
        logic taken;
        beat_k = 0;
        taken = 1'b0;
        forever begin
            @(posedge aclk);
            #1;
            for (int i = 0; i < num_src; i++) begin
                r_ready[i] = ($urandom % 4) != 0;
            end
            m_axi_arready = ($urandom % 3) != 0;
            if (taken) begin
                m_axi_rvalid = 1'b0;
            end
            if (!m_axi_rvalid && mem_q.size() > 0 && ($urandom % 4) != 0) begin
                m_axi_rvalid = 1'b1;
                m_axi_rid = mem_q[0][43:40];
                m_axi_rdata = mem_q[0][39:8] + 32'(4 * beat_k);
                m_axi_rresp = '0;
                m_axi_rlast = (beat_k == int'(mem_q[0][7:0]));
            end
            @(negedge aclk);
            if (m_axi_arvalid && m_axi_arready) begin
                mem_q.push_back({m_axi_arid, m_axi_araddr, m_axi_arlen});
            end
            taken = m_axi_rvalid && m_axi_rready;
            if (taken && m_axi_rlast) begin
                void'(mem_q.pop_front());
                beat_k = 0;
            end else if (taken) begin
                beat_k++;
            end
        end
    endtask

    task automatic check_ar_side();
        int want;
        bit can_load;
        logic [43:0] head;
        logic [41:0] req;
        // The registered request leaves before this cycle's grant is queued behind it
        if (m_axi_arvalid && m_axi_arready) begin
            checks++;
            assert (granted_q.size() > 0) else note_failure("m_axi_ar carried an extra request");
            if (granted_q.size() > 0) begin
                head = granted_q.pop_front();
                check_eq("m_axi_arid", 64'(m_axi_arid), 64'(head[43:40]));
                check_eq("m_axi_araddr", 64'(m_axi_araddr), 64'(head[39:8]));
                check_eq("m_axi_arlen", 64'(m_axi_arlen), 64'(head[7:0]));
            end
        end
        // No source is taken while memory stalls a full AR register
        can_load = !m_axi_arvalid || m_axi_arready;
        want = -1;
        for (int k = 0; k < num_src; k++) begin
            if (can_load && want < 0 && ar_valid[(rr_ptr_model + k) % num_src]) begin
                want = (rr_ptr_model + k) % num_src;
            end
        end
        check_eq("s_ar_ready", 64'(ar_ready), (want < 0) ? 64'd0 : 64'd1 << want);
        if (want >= 0) begin
            if (exp_ar[want].size() > 0) begin
                req = exp_ar[want].pop_front();
                granted_q.push_back({2'(want), req});
            end
            rr_ptr_model = (want + 1) % num_src;
            if (ar_valid == '1) begin
                rr_full_cnt++;
            end
        end
    endtask

    task automatic check_r_side();
        logic [34:0] beat;
        checks++;
        assert ($onehot0(r_valid)) else note_failure("more than one source saw a read beat");
        for (int i = 0; i < num_src; i++) begin
            if (r_valid[i] && r_ready[i]) begin
                beats_seen++;
                assert (exp_beat[i].size() > 0) else
                    note_failure($sformatf("source %0d got a beat it did not ask for", i));
                if (exp_beat[i].size() > 0) begin
                    beat = exp_beat[i].pop_front();
                    check_eq($sformatf("s%0d_r_id", i), 64'(r_id[i]), 64'(beat[34:33]));
                    check_eq($sformatf("s%0d_r_data", i), 64'(r_data[i]), 64'(beat[32:1]));
                    check_eq($sformatf("s%0d_r_last", i), 64'(r_last[i]), 64'(beat[0]));
                    check_eq($sformatf("s%0d_r_resp", i), 64'(r_resp[i]), 64'd0);
                end
            end
        end
    endtask

    function automatic bit all_done();
        bit done;
        done = (granted_q.size() == 0);
        for (int i = 0; i < num_src; i++) begin
            done = done && exp_ar[i].size() == 0 && exp_beat[i].size() == 0;
        end
        return done;
    endfunction

    always @(negedge aclk) begin
        if (rst_n) begin
            check_ar_side();
            check_r_side();
        end
    end

    initial begin
        int wait_cnt;
        errors = 0;
        checks = 0;
        rr_ptr_model = 0;
        rr_full_cnt = 0;
        beats_seen = 0;
        rst_n = 1'b0;
        ar_valid = '0;
        r_ready = '0;
        for (int i = 0; i < num_src; i++) begin
            ar_id[i] = '0;
            ar_addr[i] = '0;
            ar_len[i] = '0;
        end
        m_axi_arready = 1'b0;
        m_axi_rvalid = 1'b0;
        m_axi_rid = '0;
        m_axi_rdata = '0;
        m_axi_rresp = '0;
        m_axi_rlast = 1'b0;
        void'($urandom(32'hdd416e95));
        load_requests();
        repeat (10) @(posedge aclk);
        #1;
        rst_n = 1'b1;
        // Nothing may come out before the first request
        repeat (3) begin
            @(negedge aclk);
            checks++;
            assert (!m_axi_arvalid && r_valid == '0 && m_axi_rready) else
                note_failure("outputs were not idle after reset");
        end
        @(posedge aclk);
        #1;
        fork
            issue_requests(0);
            issue_requests(1);
            issue_requests(2);
            run_memory();
        join_none
        wait_cnt = 0;
        while (!all_done() && wait_cnt < done_timeout) begin
            @(negedge aclk);
            wait_cnt++;
        end
        assert (all_done()) else note_failure("timed out waiting for all read beats");
        check_eq("beat count", 64'(beats_seen), 64'(beats_total));
        assert (rr_full_cnt > 0) else note_failure("no grant saw all three sources requesting");
        $display("checks %0d errors %0d", checks, errors);
        if (errors == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* mem_xbar_testdata.txt */
// One hex word per request: source _ local ID _ address _ length (beats minus one)
// Each source reads from its own address range, requests per source in file order
0_0_00001000_03
1_0_00002000_01
2_0_00003000_00
0_1_00001100_00
1_1_00002100_04
2_1_00003100_02
0_2_00001200_07
1_2_00002200_00
2_2_00003200_05
0_3_00001300_01
1_3_00002300_02
2_3_00003300_01
0_0_00001400_02
1_0_00002400_07
2_0_00003400_03
0_1_00001500_05
1_1_00002500_03
2_1_00003500_00
0_2_00001600_00
1_2_00002600_01
2_2_00003600_06

/* verilog.f */
+incdir+.
mem_xbar_pkg.sv
rd_beat_if.sv
ar_arbiter.sv
rd_beat_fifo.sv
rd_resp_router.sv
rrx_mem_xbar.sv
tb_rrx_mem_xbar.sv

/* run_sim.sh */
#!/bin/sh
# Builds the testbench with Verilator and runs it from the project root
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -Wno-fatal -f verilog.f \
    --top-module tb_rrx_mem_xbar -o tb_sim &&
./obj_dir/tb_sim | tee /dev/stderr | grep -q "^TESTBENCH PASSED$" ||
{ echo "simulation did not pass" >&2; exit 1; }
